/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

   localparam int ADDR_W = 32;
   localparam int WORDS_PER_LINE = 4;
   localparam int LINE_OFS_W = 4;

   typedef logic [ADDR_W-1:0] addr_t;

   // control-flow class found at refill time
   typedef enum logic [2:0] {
      pd_none    = 3'd0,
      pd_cond_br = 3'd1,
      pd_ret     = 3'd2,
      pd_j       = 3'd3,
      pd_jr      = 3'd4,
      pd_jal     = 3'd5,
      pd_jalr    = 3'd6
   } pd_class_t;

   // one cache line with its predecode classes
   typedef struct packed {
      logic [WORDS_PER_LINE-1:0][31:0] words;
      pd_class_t [WORDS_PER_LINE-1:0]  pd;
   } line_entry_t;

   // full line address, so the width does not depend on the set count
   typedef struct packed {
      logic                       valid;
      logic [ADDR_W-LINE_OFS_W-1:0] line_addr;
   } tag_entry_t;

   typedef struct packed {
      addr_t     pc;
      logic [31:0] insn;
      pd_class_t pd;
      logic      pred_taken;
      addr_t     pred_target;
   } fetch_entry_t;

   // wishbone classic, master to slave
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      addr_t      adr;
      logic [3:0] sel;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* source/insn_predecode.sv */
`timescale 1ns/100ps
`default_nettype none

module insn_predecode import fetch_pkg::*;
(
   input  wire [31:0] insn,
   output pd_class_t  pd
);

   logic [6:0] opcode;
   logic [4:0] rd;
   logic [4:0] rs1;
   logic       rd_link;
   logic       rs1_link;

   assign opcode = insn[6:0];
   assign rd = insn[11:7];
   assign rs1 = insn[19:15];

   // x1 and x5 are the link registers
   assign rd_link = (rd == 5'd1) || (rd == 5'd5);
   assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

   always_comb
   begin
      pd = pd_none;
      case (opcode)
         7'h63:
         begin
            pd = pd_cond_br;
         end
         7'h67:
         begin
            // rd of zero means no link is written
            if (rd != 5'd0)
               pd = pd_jalr;
            else if (rs1_link)
               pd = pd_ret;
            else
               pd = pd_jr;
         end
         7'h6f:
         begin
            pd = rd_link ? pd_jal : pd_j;
         end
         default:
         begin
            pd = pd_none;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/line_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module line_ram
#(
   parameter int LG_DEPTH = 4,
   parameter type entry_t = logic
)
(
   input  wire                clk,
   input  wire [LG_DEPTH-1:0] rd_addr,
   output entry_t             rd_data,
   input  wire                wr_en,
   input  wire [LG_DEPTH-1:0] wr_addr,
   input  wire entry_t        wr_data
);

   localparam int DEPTH = 1 << LG_DEPTH;

   entry_t mem [DEPTH];

   // read sees the old entry on a same-index write
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* source/refill_master.sv */
`timescale 1ns/100ps
`default_nettype none

module refill_master import fetch_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire         refill_start,
   input  wire addr_t  refill_addr,
   output wb_req_t     wb_o,
   input  wire wb_rsp_t wb_i,
   output logic        line_wr,
   output line_entry_t line_data,
   output tag_entry_t  tag_data,
   output logic        refill_done
);

   typedef enum logic [2:0] {rf_idle, rf_bus, rf_gap, rf_write, rf_done} rf_state_t;

   rf_state_t                    state;
   logic [1:0]                   word_cnt;
   logic [ADDR_W-LINE_OFS_W-1:0] line_addr;
   line_entry_t                  line_buf;
   pd_class_t                    word_pd;

   // classify each word as it arrives
   insn_predecode u_predecode
   (
      .insn (wb_i.dat),
      .pd   (word_pd)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= rf_idle;
         word_cnt <= 2'd0;
      end
      else
      begin
         case (state)
            rf_idle:
               if (refill_start)
               begin
                  state <= rf_bus;
                  word_cnt <= 2'd0;
               end
            rf_bus:
               if (wb_i.ack)
               begin
                  // last word goes to the array write, others take a bus gap
                  state <= (word_cnt == 2'd3) ? rf_write : rf_gap;
                  word_cnt <= word_cnt + 2'd1;
               end
            rf_gap:
               state <= rf_bus;
            rf_write:
               state <= rf_done;
            default:
               state <= rf_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == rf_idle && refill_start)
      begin
         line_addr <= refill_addr[ADDR_W-1:LINE_OFS_W];
      end
      if (state == rf_bus && wb_i.ack)
      begin
         line_buf.words[word_cnt] <= wb_i.dat;
         line_buf.pd[word_cnt] <= word_pd;
      end
   end

   assign wb_o.cyc = (state == rf_bus);
   assign wb_o.stb = (state == rf_bus);
   assign wb_o.we = 1'b0;
   assign wb_o.sel = 4'hf;
   assign wb_o.adr = {line_addr, word_cnt, 2'b00};

   assign line_wr = (state == rf_write);
   assign refill_done = (state == rf_done);
   assign line_data = line_buf;
   assign tag_data.valid = 1'b1;
   assign tag_data.line_addr = line_addr;

endmodule

`default_nettype wire

/* source/fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import fetch_pkg::*;
#(
   parameter int LG_FQ_DEPTH = 3
)
(
   input  wire               clk,
   input  wire               reset,
   input  wire               clear,
   input  wire               push,
   input  wire fetch_entry_t push_entry,
   output logic              full,
   output logic              head_valid,
   output fetch_entry_t      head,
   input  wire               pop
);

   localparam int DEPTH = 1 << LG_FQ_DEPTH;

   fetch_entry_t           mem [DEPTH];
   logic [LG_FQ_DEPTH:0]   head_ptr;
   logic [LG_FQ_DEPTH:0]   tail_ptr;
   logic                   do_push;
   logic                   do_pop;

   // extra pointer bit tells full from empty
   assign full = (head_ptr[LG_FQ_DEPTH] != tail_ptr[LG_FQ_DEPTH]) &&
                 (head_ptr[LG_FQ_DEPTH-1:0] == tail_ptr[LG_FQ_DEPTH-1:0]);
   assign head_valid = (head_ptr != tail_ptr);
   assign head = mem[head_ptr[LG_FQ_DEPTH-1:0]];

   assign do_push = push && !full;
   assign do_pop = pop && head_valid;

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[tail_ptr[LG_FQ_DEPTH-1:0]] <= push_entry;
      end
   end

   // clear overrides push and pop
   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         head_ptr <= '0;
         tail_ptr <= '0;
      end
      else
      begin
         if (do_push)
         begin
            tail_ptr <= tail_ptr + 1'b1;
         end
         if (do_pop)
         begin
            head_ptr <= head_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* source/fetch_control.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_control import fetch_pkg::*;
#(
   parameter int LG_SETS = 4
)
(
   input  wire                clk,
   input  wire                reset,
   input  wire                restart_valid,
   input  wire addr_t         restart_pc,
   output logic               restart_ack,
   input  wire                flush_req,
   output logic               flush_complete,
   output logic [LG_SETS-1:0] rd_index,
   input  wire tag_entry_t    tag_out,
   input  wire line_entry_t   line_out,
   output logic               sweep_wr,
   output logic [LG_SETS-1:0] sweep_index,
   output logic               refill_start,
   output addr_t              refill_addr,
   input  wire                refill_done,
   input  wire                fq_full,
   output logic               fq_push,
   output fetch_entry_t       fq_entry,
   output logic               fq_clear
);

   typedef enum logic [2:0] {st_sweep, st_idle, st_active, st_refill, st_stall} state_t;

   state_t             state;
   state_t             n_state;
   logic [LG_SETS-1:0] sweep_cnt;
   addr_t              req_pc;
   addr_t              n_req_pc;
   addr_t              res_pc;
   logic               res_valid;
   logic               n_res_valid;
   logic               restart_seen;
   logic               flush_pend;
   logic               can_serve;
   logic               take_flush;
   logic               take_restart;
   logic               resolve;
   logic               hit;
   logic               miss;
   logic               is_jump;
   logic [1:0]         word_sel;
   logic [31:0]        word;
   pd_class_t          word_pd;
   addr_t              jump_imm;
   addr_t              jump_target;

   // compare stage works on the read issued last cycle
   assign word_sel = res_pc[LINE_OFS_W-1:2];
   assign word = line_out.words[word_sel];
   assign word_pd = line_out.pd[word_sel];
   assign hit = tag_out.valid && (tag_out.line_addr == res_pc[ADDR_W-1:LINE_OFS_W]);

   // only direct jumps redirect
   assign is_jump = (word_pd == pd_jal) || (word_pd == pd_j);
   assign jump_imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
   assign jump_target = res_pc + jump_imm;

   // flush first, then restart, then normal resolve
   assign can_serve = (state == st_idle) || (state == st_active) || (state == st_stall);
   assign take_flush = flush_pend && can_serve;
   assign take_restart = restart_seen && can_serve && !flush_pend;
   assign resolve = (state == st_active) && res_valid && !take_flush && !take_restart;

   assign fq_push = resolve && hit && !fq_full;
   assign miss = resolve && !hit;
   assign fq_clear = take_flush || take_restart;

   always_comb
   begin
      fq_entry.pc = res_pc;
      fq_entry.insn = word;
      fq_entry.pd = word_pd;
      fq_entry.pred_taken = is_jump;
      fq_entry.pred_target = is_jump ? jump_target : res_pc + 32'd4;
   end

   assign rd_index = req_pc[LINE_OFS_W +: LG_SETS];
   assign sweep_wr = (state == st_sweep);
   assign sweep_index = sweep_cnt;

   always_comb
   begin
      n_state = state;
      n_req_pc = req_pc;
      n_res_valid = 1'b0;
      case (state)
         st_sweep:
            if (&sweep_cnt)
               n_state = st_idle;
         st_active:
         begin
            // issue the next sequential lookup
            n_res_valid = 1'b1;
            n_req_pc = req_pc + 32'd4;
            if (resolve)
            begin
               if (!hit)
               begin
                  n_state = st_refill;
                  n_req_pc = res_pc;
                  n_res_valid = 1'b0;
               end
               else if (fq_full)
               begin
                  n_state = st_stall;
                  n_req_pc = res_pc;
                  n_res_valid = 1'b0;
               end
               else if (is_jump)
               begin
                  // drop the lookup in flight
                  n_req_pc = jump_target;
                  n_res_valid = 1'b0;
               end
            end
         end
         st_refill:
            if (refill_done)
               n_state = st_active;
         st_stall:
            if (!fq_full)
               n_state = st_active;
         default:
            n_state = state;
      endcase
      if (take_flush)
      begin
         n_state = st_sweep;
         n_res_valid = 1'b0;
      end
      else if (take_restart)
      begin
         n_state = st_active;
         n_req_pc = restart_pc;
         n_res_valid = 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_sweep;
         sweep_cnt <= '0;
         req_pc <= '0;
         res_valid <= 1'b0;
         restart_seen <= 1'b0;
         flush_pend <= 1'b0;
         restart_ack <= 1'b0;
         flush_complete <= 1'b0;
         refill_start <= 1'b0;
      end
      else
      begin
         state <= n_state;
         req_pc <= n_req_pc;
         res_valid <= n_res_valid;
         sweep_cnt <= take_flush ? '0 : (state == st_sweep) ? sweep_cnt + 1'b1 : sweep_cnt;
         // requester keeps valid high through the ack cycle
         restart_seen <= take_restart ? 1'b0 : (restart_seen || (restart_valid && !restart_ack));
         flush_pend <= take_flush ? flush_req : (flush_pend || flush_req);
         restart_ack <= take_restart;
         flush_complete <= (state == st_sweep) && (&sweep_cnt);
         refill_start <= miss;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_active)
      begin
         res_pc <= req_pc;
      end
      if (miss)
      begin
         refill_addr <= {res_pc[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
      end
   end

endmodule

`default_nettype wire

/* source/fetch_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend import fetch_pkg::*;
#(
   parameter int LG_SETS = 4,
   parameter int LG_FQ_DEPTH = 3
)
(
   input  wire          clk,
   input  wire          reset,
   input  wire          restart_valid,
   input  wire addr_t   restart_pc,
   output logic         restart_ack,
   input  wire          flush_req,
   output logic         flush_complete,
   output logic         insn_valid,
   output fetch_entry_t insn,
   input  wire          insn_ack,
   output wb_req_t      wb_o,
   input  wire wb_rsp_t wb_i
);

   logic [LG_SETS-1:0] rd_index;
   logic [LG_SETS-1:0] sweep_index;
   logic [LG_SETS-1:0] wr_index;
   logic               sweep_wr;
   logic               line_wr;
   logic               tag_wr;
   tag_entry_t         tag_out;
   tag_entry_t         tag_data;
   tag_entry_t         tag_wr_data;
   line_entry_t        line_out;
   line_entry_t        line_data;
   logic               refill_start;
   addr_t              refill_addr;
   logic               refill_done;
   logic               fq_full;
   logic               fq_push;
   logic               fq_clear;
   fetch_entry_t       fq_entry;

   // refill write wins, sweep writes an invalid tag
   assign wr_index = line_wr ? tag_data.line_addr[LG_SETS-1:0] : sweep_index;
   assign tag_wr = line_wr || sweep_wr;
   assign tag_wr_data = line_wr ? tag_data : '0;

   fetch_control #(.LG_SETS(LG_SETS)) u_control
   (
      .clk            (clk),
      .reset          (reset),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .restart_ack    (restart_ack),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .rd_index       (rd_index),
      .tag_out        (tag_out),
      .line_out       (line_out),
      .sweep_wr       (sweep_wr),
      .sweep_index    (sweep_index),
      .refill_start   (refill_start),
      .refill_addr    (refill_addr),
      .refill_done    (refill_done),
      .fq_full        (fq_full),
      .fq_push        (fq_push),
      .fq_entry       (fq_entry),
      .fq_clear       (fq_clear)
   );

   line_ram #(.LG_DEPTH(LG_SETS), .entry_t(tag_entry_t)) tag_ram
   (
      .clk     (clk),
      .rd_addr (rd_index),
      .rd_data (tag_out),
      .wr_en   (tag_wr),
      .wr_addr (wr_index),
      .wr_data (tag_wr_data)
   );

   line_ram #(.LG_DEPTH(LG_SETS), .entry_t(line_entry_t)) data_ram
   (
      .clk     (clk),
      .rd_addr (rd_index),
      .rd_data (line_out),
      .wr_en   (line_wr),
      .wr_addr (wr_index),
      .wr_data (line_data)
   );

   refill_master u_refill
   (
      .clk          (clk),
      .reset        (reset),
      .refill_start (refill_start),
      .refill_addr  (refill_addr),
      .wb_o         (wb_o),
      .wb_i         (wb_i),
      .line_wr      (line_wr),
      .line_data    (line_data),
      .tag_data     (tag_data),
      .refill_done  (refill_done)
   );

   fetch_queue #(.LG_FQ_DEPTH(LG_FQ_DEPTH)) u_queue
   (
      .clk        (clk),
      .reset      (reset),
      .clear      (fq_clear),
      .push       (fq_push),
      .push_entry (fq_entry),
      .full       (fq_full),
      .head_valid (insn_valid),
      .head       (insn),
      .pop        (insn_ack)
   );

endmodule

`default_nettype wire

/* verif/fetch_frontend_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_asserts import fetch_pkg::*;
(
   input  wire          clk,
   input  wire          reset,
   input  wire wb_req_t wb_o,
   input  wire wb_rsp_t wb_i,
   input  wire          insn_valid,
   input  wire          insn_ack
);

   // number of failed assertions
   int fail_count = 0;

   stb_needs_cyc : assert property (@(posedge clk) disable iff (reset)
      wb_o.stb |-> wb_o.cyc)
   else
   begin
      $error("wishbone stb high without cyc");
      fail_count++;
   end

   // classic cycle holds the address until ack
   adr_held : assert property (@(posedge clk) disable iff (reset)
      (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)))
   else
   begin
      $error("wishbone adr or stb changed before ack");
      fail_count++;
   end

   ack_needs_valid : assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> insn_valid)
   else
   begin
      $error("insn_ack high while insn_valid low");
      fail_count++;
   end

   valid_known : assert property (@(posedge clk) disable iff (reset)
      !$isunknown(insn_valid))
   else
   begin
      $error("insn_valid is unknown after reset");
      fail_count++;
   end

endmodule

bind fetch_frontend fetch_frontend_asserts u_asserts
(
   .clk        (clk),
   .reset      (reset),
   .wb_o       (wb_o),
   .wb_i       (wb_i),
   .insn_valid (insn_valid),
   .insn_ack   (insn_ack)
);

`default_nettype wire

/* verif/fetch_frontend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_tb import fetch_pkg::*;
();

   // straight-line code, jump mix, and a closed four-line loop
   localparam addr_t code_a = 32'h0000_0100;
   localparam addr_t code_j = 32'h0000_0300;
   localparam addr_t code_r = 32'h0000_0400;
   localparam int total_entries = 12 + 7 + 40 + 20 + 5 + 10 + 12;

   logic         clk = 1'b0;
   logic         reset;
   logic         restart_valid;
   addr_t        restart_pc;
   logic         restart_ack;
   logic         flush_req;
   logic         flush_complete;
   logic         insn_valid;
   fetch_entry_t insn;
   logic         insn_ack;
   wb_req_t      wb_o;
   wb_rsp_t      wb_i;

   integer       seed = 32'hb0a6fcbb;
   logic [31:0]  mem [0:1023];
   pd_class_t    exp_pd [0:1023];
   logic         exp_taken [0:1023];
   addr_t        exp_tgt [0:1023];
   addr_t        bus_log [$];

   fetch_frontend #(.LG_SETS(4), .LG_FQ_DEPTH(3)) dut
   (
      .clk            (clk),
      .reset          (reset),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .restart_ack    (restart_ack),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .insn_valid     (insn_valid),
      .insn           (insn),
      .insn_ack       (insn_ack),
      .wb_o           (wb_o),
      .wb_i           (wb_i)
   );

   initial
   begin
      forever
      begin
         #5 clk = ~clk;
      end
   end

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_entry(input string name, input fetch_entry_t exp, input fetch_entry_t act);
      if (act !== exp)
      begin
         $display("ERR time %0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp)
      begin
         $display("ERR time %0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERR time %0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic place_word(input addr_t at, input logic [31:0] word, input pd_class_t cls,
                             input logic taken, input addr_t target);
      mem[at[11:2]] = word;
      exp_pd[at[11:2]] = cls;
      exp_taken[at[11:2]] = taken;
      exp_tgt[at[11:2]] = target;
   endtask

   // J-type encoding built from the wanted target
   task automatic place_jump(input addr_t at, input logic [4:0] rd, input addr_t target,
                             input pd_class_t cls);
      addr_t ofs;
      ofs = target - at;
      place_word(at, {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, 7'h6f}, cls, 1'b1, target);
   endtask

   task automatic fill_memory();
      for (int i = 0; i < 1024; i++)
      begin
         // filler is always an op-imm word
         mem[i] = $random(seed);
         mem[i][6:0] = 7'h13;
         exp_pd[i] = pd_none;
         exp_taken[i] = 1'b0;
         exp_tgt[i] = '0;
      end
      place_word(code_j + 32'h04, {7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'h63}, pd_cond_br, 1'b0, '0);
      place_jump(code_j + 32'h08, 5'd1, code_j + 32'h28, pd_jal);
      place_word(code_j + 32'h28, {12'h000, 5'd2, 3'b000, 5'd1, 7'h67}, pd_jalr, 1'b0, '0);
      place_jump(code_j + 32'h2c, 5'd0, code_j + 32'h10, pd_j);
      place_jump(code_r + 32'h3c, 5'd0, code_r, pd_j);
   endtask

   function automatic fetch_entry_t expected_entry(input addr_t pc);
      fetch_entry_t e;
      e.pc = pc;
      e.insn = mem[pc[11:2]];
      e.pd = exp_pd[pc[11:2]];
      e.pred_taken = exp_taken[pc[11:2]];
      e.pred_target = exp_taken[pc[11:2]] ? exp_tgt[pc[11:2]] : pc + 32'd4;
      return e;
   endfunction

   // wishbone slave with 0 to 3 cycles of ack delay
   initial
   begin : mem_model
      int delay;
      wb_i = '0;
      forever
      begin
         @(negedge clk);
         if (wb_i.ack)
         begin
            wb_i = '0;
         end
         else if (wb_o.cyc && wb_o.stb)
         begin
            bus_log.push_back(wb_o.adr);
            // only full-word reads are expected
            check_bit("wb_o.we", 1'b0, wb_o.we);
            for (int b = 0; b < 4; b++)
               check_bit($sformatf("wb_o.sel[%0d]", b), 1'b1, wb_o.sel[b]);
            delay = $random(seed) & 32'd3;
            repeat (delay) @(negedge clk);
            wb_i.ack = 1'b1;
            wb_i.dat = mem[wb_o.adr[11:2]];
         end
      end
   end

   task automatic do_restart(input addr_t pc);
      restart_pc = pc;
      restart_valid = 1'b1;
      @(negedge clk);
      while (!restart_ack)
         @(negedge clk);
      restart_valid = 1'b0;
      bus_log.delete();
   endtask

   task automatic get_entry(output fetch_entry_t e);
      while (!insn_valid)
         @(negedge clk);
      e = insn;
      insn_ack = 1'b1;
      @(negedge clk);
      insn_ack = 1'b0;
   endtask

   // follows the predicted path through the placed words
   task automatic check_stream(input addr_t start, input int count);
      addr_t        pc;
      fetch_entry_t got;
      fetch_entry_t want;
      pc = start;
      repeat (count)
      begin
         get_entry(got);
         want = expected_entry(pc);
         check_entry("insn", want, got);
         pc = want.pred_target;
      end
   endtask

   task automatic check_bus_seq(input addr_t base);
      for (int i = 0; i < bus_log.size(); i++)
         check_addr("wb_o.adr", base + addr_t'(4 * i), bus_log[i]);
   endtask

   task automatic test_reset_sweep();
      int pulses;
      pulses = 0;
      check_bit("restart_ack", 1'b0, restart_ack);
      check_bit("flush_complete", 1'b0, flush_complete);
      check_bit("wb_o.cyc", 1'b0, wb_o.cyc);
      check_bit("wb_o.stb", 1'b0, wb_o.stb);
      check_bit("insn_valid", 1'b0, insn_valid);
      check_bit("refill_start", 1'b0, dut.u_control.refill_start);
      repeat (60)
      begin
         @(negedge clk);
         if (flush_complete)
            pulses++;
         check_bit("wb_o.cyc", 1'b0, wb_o.cyc);
         check_bit("insn_valid", 1'b0, insn_valid);
      end
      if (pulses != 1)
      begin
         $display("flush_complete pulsed %0d times after reset instead of once", pulses);
         abort_run();
      end
   endtask

   task automatic test_straight_line();
      do_restart(code_a);
      check_stream(code_a, 12);
      check_bit("wb read count at least 12", 1'b1, bus_log.size() >= 12);
      check_bus_seq(code_a);
   endtask

   task automatic test_jumps();
      do_restart(code_j);
      check_stream(code_j, 7);
   endtask

   task automatic test_backpressure();
      do_restart(code_r);
      repeat (50) @(negedge clk);
      check_bit("insn_valid", 1'b1, insn_valid);
      check_stream(code_r, 40);
      check_bit("wb read count is 16", 1'b1, bus_log.size() == 16);
      check_bus_seq(code_r);
      // loop is cached now
      do_restart(code_r);
      check_stream(code_r, 20);
      check_bit("wb read count is 0", 1'b1, bus_log.size() == 0);
   endtask

   task automatic test_restart_streaming();
      do_restart(code_a);
      check_stream(code_a, 5);
      do_restart(code_j + 32'h04);
      check_stream(code_j + 32'h04, 10);
   endtask

   task automatic test_flush();
      flush_req = 1'b1;
      @(negedge clk);
      flush_req = 1'b0;
      while (!flush_complete)
         @(negedge clk);
      check_bit("insn_valid", 1'b0, insn_valid);
      // inner loop lines were cached before the flush
      do_restart(code_j + 32'h10);
      check_stream(code_j + 32'h10, 12);
      check_bit("wb read count is 8", 1'b1, bus_log.size() == 8);
      check_bus_seq(code_j + 32'h10);
   endtask

   initial
   begin : assert_monitor
      forever
      begin
         @(negedge clk);
         if (dut.u_asserts.fail_count != 0)
         begin
            $display("a bound assertion failed before time %0t", $time);
            abort_run();
         end
      end
   end

   initial
   begin : watchdog
      repeat (total_entries * 40 + 2000) @(posedge clk);
      $display("timeout: the tests did not finish in %0d cycles", total_entries * 40 + 2000);
      abort_run();
   end

   initial
   begin
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      flush_req = 1'b0;
      insn_ack = 1'b0;
      fill_memory();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      test_reset_sweep();
      test_straight_line();
      test_jumps();
      test_backpressure();
      test_restart_streaming();
      test_flush();
      if (dut.u_asserts.fail_count == 0)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
      begin
         $display("a bound assertion failed during the run");
         abort_run();
      end
   end

endmodule

`default_nettype wire

/* fetch_frontend.f */
source/fetch_pkg.sv
source/insn_predecode.sv
source/line_ram.sv
source/refill_master.sv
source/fetch_queue.sv
source/fetch_control.sv
source/fetch_frontend.sv
verif/fetch_frontend_asserts.sv
verif/fetch_frontend_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - target: any(rtl, test)
    files:
      - source/fetch_pkg.sv
      - source/insn_predecode.sv
      - source/line_ram.sv
      - source/refill_master.sv
      - source/fetch_queue.sv
      - source/fetch_control.sv
      - source/fetch_frontend.sv
  - target: test
    files:
      - verif/fetch_frontend_asserts.sv
      - verif/fetch_frontend_tb.sv
